/* files.f */
obi_pkg.sv
mm_map_pkg.sv
sram_bank.sv
mm_pseudo_periph.sv
mm_data_router.sv
mm_ram.sv
tb_mm_ram.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the RAM subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_mm_ram -f files.f -o sim_mm_ram \
  && ./obj_dir/sim_mm_ram 2>&1 | tee /dev/stderr | grep -qF "Finished with no errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* tb_mm_ram.sv */
// testbench for the RAM subsystem with RAM traffic, print register and timer checks
`default_nettype none

module tb_mm_ram;
  import obi_pkg::*;
  import mm_map_pkg::*;

  localparam int ClkPeriod = 20;
  localparam int NumFill   = 24;
  localparam int NumRand   = 64;
  localparam int NumOps    = 2 * NumFill + 2 * NumRand + 100;
  localparam addr_t EdgeAddr [4] = '{32'h0000_0000, 32'h0000_0ffc, 32'h0000_1000, 32'h0000_1ffc};

  logic       clk_i;
  logic       rst_ni;
  obi_req_t   data_req_i;
  obi_resp_t  data_resp_o;
  irq_id_t    irq_id_i;
  logic       irq_ack_i;
  logic       irq_timer_o;
  logic       print_valid_o;
  logic [7:0] print_char_o;

  // reference state
  data_t      shadow [int unsigned];
  addr_t      written_q [$];
  obi_resp_t  exp_q [$];
  data_t      m_mask;
  data_t      m_count;
  logic       m_irq;
  logic       m_print_valid;
  logic [7:0] m_print_char;
  logic       prev_req;
  data_t      rng;

  mm_ram uut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_req_i    (data_req_i),
    .data_resp_o   (data_resp_o),
    .irq_id_i      (irq_id_i),
    .irq_ack_i     (irq_ack_i),
    .irq_timer_o   (irq_timer_o),
    .print_valid_o (print_valid_o),
    .print_char_o  (print_char_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  function automatic data_t xorshift(data_t x);
    data_t y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic data_t next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // word index over the whole 8 KiB
  function automatic int unsigned word_key(addr_t a);
    return {21'd0, a[12:2]};
  endfunction

  function automatic data_t merge_bytes(data_t old, data_t wdata, be_t be);
    data_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

  // expected response, from the address map and the model state before the edge
  function automatic obi_resp_t ref_resp(obi_req_t r);
    obi_resp_t e;
    e = '0;
    e.gnt = 1'b1;
    e.rvalid = 1'b1;
    if (r.addr < addr_t'(RamBytes)) begin
      if (!r.we) begin
        e.rdata = shadow[word_key(r.addr)];
      end
    end else if (r.addr == PrintAddr) begin
      e.rdata = '0;
    end else if (r.addr == TimerMaskAddr) begin
      e.rdata = r.we ? '0 : m_mask;
    end else if (r.addr == TimerCountAddr) begin
      e.rdata = r.we ? '0 : m_count;
    end else begin
      e.err = 1'b1;
    end
    return e;
  endfunction

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_resp(obi_resp_t got, obi_resp_t exp);
    if (got.rvalid !== exp.rvalid || got.err !== exp.err || got.rdata !== exp.rdata) begin
      fail_now($sformatf("mismatch at %0t: response err %b rdata %h, expected err %b rdata %h",
                         $time, got.err, got.rdata, exp.err, exp.rdata));
    end
  endtask

  task automatic check_print(logic got_valid, logic [7:0] got_char,
                             logic exp_valid, logic [7:0] exp_char);
    if (got_valid !== exp_valid || (exp_valid && got_char !== exp_char)) begin
      fail_now($sformatf("mismatch at %0t: print %b/%h, expected %b/%h",
                         $time, got_valid, got_char, exp_valid, exp_char));
    end
  endtask

  task automatic check_irq(logic got, logic exp);
    if (got !== exp) begin
      fail_now($sformatf("mismatch at %0t: timer irq %b, expected %b", $time, got, exp));
    end
  endtask

  // reference model, one step per cycle on the inputs the next edge samples
  always @(negedge clk_i) begin
    data_t cnt;
    logic  t_wr;
    if (rst_ni) begin
      check_irq(irq_timer_o, m_irq);
      check_print(print_valid_o, print_char_o, m_print_valid, m_print_char);
      cnt = m_count;
      t_wr = 1'b0;
      m_print_valid = 1'b0;
      if (data_req_i.req) begin
        exp_q.push_back(ref_resp(data_req_i));
        if (data_req_i.we) begin
          if (data_req_i.addr < addr_t'(RamBytes)) begin
            shadow[word_key(data_req_i.addr)] = merge_bytes(
              shadow.exists(word_key(data_req_i.addr)) ? shadow[word_key(data_req_i.addr)] : '0,
              data_req_i.wdata, data_req_i.be);
          end else if (data_req_i.addr == PrintAddr) begin
            m_print_valid = 1'b1;
            m_print_char = data_req_i.wdata[7:0];
          end else if (data_req_i.addr == TimerMaskAddr) begin
            m_mask = data_req_i.wdata;
            t_wr = 1'b1;
          end else if (data_req_i.addr == TimerCountAddr) begin
            m_count = data_req_i.wdata;
            t_wr = 1'b1;
          end
        end
      end
      // countdown and irq only move in cycles without a timer write
      if (!t_wr) begin
        if (cnt != '0) begin
          m_count = cnt - data_t'(1);
        end
        if (irq_ack_i && irq_id_i == TimerIrqId) begin
          m_irq = 1'b0;
        end else if (cnt == data_t'(1) && m_mask[TimerIrqId]) begin
          m_irq = 1'b1;
        end
      end
    end
  end

  // response compare, rvalid exactly one cycle after each grant
  always @(negedge clk_i) begin
    obi_resp_t exp;
    if (rst_ni) begin
      if (data_resp_o.gnt !== data_req_i.req) begin
        fail_now($sformatf("mismatch at %0t: gnt %b, expected %b",
                           $time, data_resp_o.gnt, data_req_i.req));
      end
      if (data_resp_o.rvalid !== prev_req) begin
        fail_now($sformatf("mismatch at %0t: rvalid %b, expected %b",
                           $time, data_resp_o.rvalid, prev_req));
      end
      if (data_resp_o.rvalid) begin
        if (exp_q.size() == 0) begin
          fail_now("a response arrived with no request outstanding");
        end
        exp = exp_q.pop_front();
        check_resp(data_resp_o, exp);
      end
      prev_req = data_req_i.req;
    end
  end

  task automatic drive(obi_req_t r, logic ack, irq_id_t id);
    @(posedge clk_i);
    #2;
    data_req_i = r;
    irq_ack_i = ack;
    irq_id_i = id;
  endtask

  task automatic access(logic we, be_t be, addr_t addr, data_t wdata);
    obi_req_t r;
    r.req = 1'b1;
    r.we = we;
    r.be = be;
    r.addr = addr;
    r.wdata = wdata;
    drive(r, 1'b0, '0);
  endtask

  task automatic idle(int n);
    repeat (n) drive('0, 1'b0, '0);
  endtask

  task automatic ack_irq(irq_id_t id);
    drive('0, 1'b1, id);
    idle(1);
  endtask

  task automatic wait_irq(int limit);
    int n;
    n = 0;
    while (irq_timer_o !== 1'b1) begin
      if (n == limit) begin
        fail_now("the timer interrupt was not raised within the expected time");
      end
      idle(1);
      n++;
    end
  endtask

  initial begin
    addr_t a;
    data_t d;
    rng = 32'd67;
    m_mask = '0;
    m_count = '0;
    m_irq = 1'b0;
    m_print_valid = 1'b0;
    m_print_char = '0;
    prev_req = 1'b0;
    data_req_i = '0;
    irq_id_i = '0;
    irq_ack_i = 1'b0;
    rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // full-word fill first so that every later read hits a defined word
    for (int i = 0; i < NumFill; i++) begin
      a = (i < 4) ? EdgeAddr[i] : (next_rand() & 32'h0000_1ffc);
      access(1'b1, 4'hf, a, next_rand());
      written_q.push_back(a);
    end
    idle(1);

    // back-to-back mix of byte-enabled writes and reads
    for (int i = 0; i < NumRand; i++) begin
      a = written_q[next_rand() % written_q.size()];
      d = next_rand();
      if (d[0]) begin
        access(1'b1, be_t'(d[7:4]), a, next_rand());
      end else begin
        access(1'b0, 4'h0, a, '0);
      end
    end
    foreach (written_q[i]) access(1'b0, 4'h0, written_q[i], '0);
    idle(2);

    // unmapped accesses, RAM must stay untouched
    access(1'b1, 4'hf, 32'h0000_2000, next_rand());
    access(1'b0, 4'h0, 32'h0000_2000, '0);
    access(1'b1, 4'hf, 32'h1000_0004, next_rand());
    access(1'b0, 4'h0, 32'h1500_0008, '0);
    access(1'b1, 4'h3, 32'h8000_0ffc, next_rand());
    idle(1);
    for (int i = 0; i < 4; i++) access(1'b0, 4'h0, EdgeAddr[i], '0);
    idle(2);

    // print strobes, single and back to back
    access(1'b1, 4'hf, PrintAddr, next_rand());
    idle(2);
    access(1'b1, 4'hf, PrintAddr, next_rand());
    access(1'b1, 4'hf, PrintAddr, next_rand());
    access(1'b0, 4'h0, PrintAddr, '0);
    idle(2);

    // timer enabled, countdown read midway, then ack by id
    access(1'b1, 4'hf, TimerMaskAddr, data_t'(1) << TimerIrqId);
    access(1'b1, 4'hf, TimerCountAddr, 32'd12);
    idle(4);
    access(1'b0, 4'h0, TimerCountAddr, '0);
    access(1'b0, 4'h0, TimerMaskAddr, '0);
    wait_irq(20);
    ack_irq(5'd3);
    check_irq(irq_timer_o, 1'b1);
    ack_irq(TimerIrqId);
    check_irq(irq_timer_o, 1'b0);

    // timer masked, expires quietly
    access(1'b1, 4'hf, TimerMaskAddr, '0);
    access(1'b1, 4'hf, TimerCountAddr, 32'd5);
    idle(8);
    access(1'b0, 4'h0, TimerCountAddr, '0);
    idle(2);
    check_irq(irq_timer_o, 1'b0);

    idle(3);
    if (exp_q.size() == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      fail_now("responses were still outstanding at the end of the run");
    end
  end

  // watchdog sized from the operation count
  initial begin
    #((NumOps + 200) * ClkPeriod);
    $display("timeout: the test sequence did not complete in time");
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* mm_ram.sv */
// RAM subsystem top: data router, two SRAM banks and pseudo peripheral block
`default_nettype none

module mm_ram
  import obi_pkg::*;
  import mm_map_pkg::*;
(
  input  wire        clk_i,
  input  wire        rst_ni,

  input  obi_req_t   data_req_i,
  output obi_resp_t  data_resp_o,

  input  irq_id_t    irq_id_i,
  input  wire        irq_ack_i,
  output logic       irq_timer_o,

  output logic       print_valid_o,
  output logic [7:0] print_char_o
);

  bank_req_t   bank0_req;
  bank_req_t   bank1_req;
  data_t       bank0_rdata;
  data_t       bank1_rdata;
  periph_req_t periph_req;
  data_t       periph_rdata;

  mm_data_router router_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .data_req_i     (data_req_i),
    .data_resp_o    (data_resp_o),
    .bank0_req_o    (bank0_req),
    .bank1_req_o    (bank1_req),
    .bank0_rdata_i  (bank0_rdata),
    .bank1_rdata_i  (bank1_rdata),
    .periph_req_o   (periph_req),
    .periph_rdata_i (periph_rdata)
  );

  // low half of the RAM
  sram_bank #(
    .NumWords (BankWords)
  ) bank0_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .bank_req_i (bank0_req),
    .rdata_o    (bank0_rdata)
  );

  // high half of the RAM
  sram_bank #(
    .NumWords (BankWords)
  ) bank1_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .bank_req_i (bank1_req),
    .rdata_o    (bank1_rdata)
  );

  mm_pseudo_periph periph_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .periph_req_i   (periph_req),
    .periph_rdata_o (periph_rdata),
    .irq_id_i       (irq_id_i),
    .irq_ack_i      (irq_ack_i),
    .irq_timer_o    (irq_timer_o),
    .print_valid_o  (print_valid_o),
    .print_char_o   (print_char_o)
  );

endmodule

`default_nettype wire

/* mm_data_router.sv */
// data request decoder and response merge for the RAM banks and pseudo peripherals
`default_nettype none

module mm_data_router
  import obi_pkg::*;
  import mm_map_pkg::*;
(
  input  wire         clk_i,
  input  wire         rst_ni,
  input  obi_req_t    data_req_i,
  output obi_resp_t   data_resp_o,
  output bank_req_t   bank0_req_o,
  output bank_req_t   bank1_req_o,
  input  data_t       bank0_rdata_i,
  input  data_t       bank1_rdata_i,
  output periph_req_t periph_req_o,
  input  data_t       periph_rdata_i
);

  target_t     tgt;
  target_t     tgt_q;
  periph_reg_t sel;
  bank_addr_t  bank_addr;
  logic        valid_q;
  logic        we_q;
  data_t       src_rdata;

  // address decode, pure combinational
  always_comb begin
    tgt = TGT_ERR;
    sel = REG_PRINT;
    if (data_req_i.addr < addr_t'(RamBytes / 2)) begin
      tgt = TGT_BANK0;
    end else if (data_req_i.addr < addr_t'(RamBytes)) begin
      tgt = TGT_BANK1;
    end else if (data_req_i.addr == PrintAddr) begin
      tgt = TGT_PERIPH;
      sel = REG_PRINT;
    end else if (data_req_i.addr == TimerMaskAddr) begin
      tgt = TGT_PERIPH;
      sel = REG_TIMER_MASK;
    end else if (data_req_i.addr == TimerCountAddr) begin
      tgt = TGT_PERIPH;
      sel = REG_TIMER_COUNT;
    end
  end

  // word index, identical bit slice in both banks
  assign bank_addr = data_req_i.addr[2 +: $bits(bank_addr_t)];

  always_comb begin
    bank0_req_o.req   = data_req_i.req && (tgt == TGT_BANK0);
    bank0_req_o.we    = data_req_i.we;
    bank0_req_o.be    = data_req_i.be;
    bank0_req_o.addr  = bank_addr;
    bank0_req_o.wdata = data_req_i.wdata;
  end

  always_comb begin
    bank1_req_o.req   = data_req_i.req && (tgt == TGT_BANK1);
    bank1_req_o.we    = data_req_i.we;
    bank1_req_o.be    = data_req_i.be;
    bank1_req_o.addr  = bank_addr;
    bank1_req_o.wdata = data_req_i.wdata;
  end

  always_comb begin
    periph_req_o.req   = data_req_i.req && (tgt == TGT_PERIPH);
    periph_req_o.we    = data_req_i.we;
    periph_req_o.sel   = sel;
    periph_req_o.wdata = data_req_i.wdata;
  end

  // response selector for the following cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tgt_q   <= TGT_BANK0;
      valid_q <= 1'b0;
      we_q    <= 1'b0;
    end else begin
      valid_q <= data_req_i.req;
      if (data_req_i.req) begin
        tgt_q <= tgt;
        we_q  <= data_req_i.we;
      end
    end
  end

  always_comb begin
    case (tgt_q)
      TGT_BANK0:  src_rdata = bank0_rdata_i;
      TGT_BANK1:  src_rdata = bank1_rdata_i;
      TGT_PERIPH: src_rdata = periph_rdata_i;
      default:    src_rdata = '0;
    endcase
  end

  // write responses carry no data
  always_comb begin
    data_resp_o.gnt    = data_req_i.req;
    data_resp_o.rvalid = valid_q;
    data_resp_o.err    = valid_q && (tgt_q == TGT_ERR);
    data_resp_o.rdata  = we_q ? '0 : src_rdata;
  end

  // every request is granted at once and answered one cycle later
  grant_then_valid_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    data_req_i.req |-> data_resp_o.gnt ##1 data_resp_o.rvalid
  );

  // no response without a grant in the cycle before
  valid_after_grant_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    data_resp_o.rvalid |-> $past(data_resp_o.gnt)
  );

endmodule

`default_nettype wire

/* mm_pseudo_periph.sv */
// pseudo peripherals: character print register and countdown timer with interrupt
`default_nettype none

module mm_pseudo_periph
  import obi_pkg::*;
  import mm_map_pkg::*;
(
  input  wire         clk_i,
  input  wire         rst_ni,
  input  periph_req_t periph_req_i,
  output data_t       periph_rdata_o,
  input  irq_id_t     irq_id_i,
  input  wire         irq_ack_i,
  output logic        irq_timer_o,
  output logic        print_valid_o,
  output logic [7:0]  print_char_o
);

  logic  print_wr;
  logic  mask_wr;
  logic  count_wr;
  logic  timer_ack;

  data_t mask_q;
  data_t count_q;
  logic  irq_q;
  logic  print_valid_q;
  logic [7:0] print_char_q;
  data_t rdata_q;

  assign print_wr  = periph_req_i.req && periph_req_i.we && (periph_req_i.sel == REG_PRINT);
  assign mask_wr   = periph_req_i.req && periph_req_i.we &&
                     (periph_req_i.sel == REG_TIMER_MASK);
  assign count_wr  = periph_req_i.req && periph_req_i.we &&
                     (periph_req_i.sel == REG_TIMER_COUNT);
  assign timer_ack = irq_ack_i && (irq_id_i == TimerIrqId);

  // timer state, writes win over counting
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q  <= '0;
      count_q <= '0;
      irq_q   <= 1'b0;
    end else if (mask_wr) begin
      mask_q <= periph_req_i.wdata;
    end else if (count_wr) begin
      count_q <= periph_req_i.wdata;
    end else begin
      if (count_q != '0) begin
        count_q <= count_q - 1'b1;
      end
      // ack has priority over a new expiry
      if (timer_ack) begin
        irq_q <= 1'b0;
      end else if (count_q == data_t'(1) && mask_q[TimerIrqId]) begin
        irq_q <= 1'b1;
      end
    end
  end

  // one-cycle print strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      print_valid_q <= 1'b0;
    end else begin
      print_valid_q <= print_wr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (print_wr) begin
      print_char_q <= periph_req_i.wdata[7:0];
    end
  end

  // registered readback, print reads as zero
  always_ff @(posedge clk_i) begin
    if (periph_req_i.req) begin
      case (periph_req_i.sel)
        REG_TIMER_MASK:  rdata_q <= mask_q;
        REG_TIMER_COUNT: rdata_q <= count_q;
        default:         rdata_q <= '0;
      endcase
    end
  end

  assign periph_rdata_o = rdata_q;
  assign irq_timer_o    = irq_q;
  assign print_valid_o  = print_valid_q;
  assign print_char_o   = print_char_q;

  // back-to-back strobes need back-to-back print writes
  print_pulse_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (print_valid_o && $past(print_valid_o)) |-> ($past(print_wr) && $past(print_wr, 2))
  );

  // counter only moves up through a write
  count_monotonic_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !count_wr |=> (count_q <= $past(count_q))
  );

endmodule

`default_nettype wire

/* sram_bank.sv */
// word-wide synchronous RAM bank with byte enables and one-cycle read latency
`default_nettype none

module sram_bank
  import obi_pkg::*;
  import mm_map_pkg::*;
#(
  parameter int unsigned NumWords = BankWords
) (
  input  wire        clk_i,
  input  wire        rst_ni,
  input  bank_req_t  bank_req_i,
  output data_t      rdata_o
);

  data_t mem_q [NumWords];
  data_t rdata_q;

  // write enabled byte lanes at the sampling edge
  always_ff @(posedge clk_i) begin
    if (bank_req_i.req && bank_req_i.we) begin
      for (int i = 0; i < $bits(be_t); i++) begin
        if (bank_req_i.be[i]) begin
          mem_q[bank_req_i.addr][8*i +: 8] <= bank_req_i.wdata[8*i +: 8];
        end
      end
    end
  end

  // read word registered, valid the cycle after req
  always_ff @(posedge clk_i) begin
    if (bank_req_i.req && !bank_req_i.we) begin
      rdata_q <= mem_q[bank_req_i.addr];
    end
  end

  assign rdata_o = rdata_q;

  // an unknown address would corrupt or read an undefined word
  addr_known_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bank_req_i.req |-> !$isunknown(bank_req_i.addr)
  );

endmodule

`default_nettype wire

/* mm_map_pkg.sv */
// address map, internal request structs and timer constants of the RAM subsystem
`default_nettype none

package mm_map_pkg;

  import obi_pkg::*;

  // 8 KiB of RAM, split into two banks
  localparam int unsigned RamBytes  = 8192;
  localparam int unsigned BankWords = 1024;

  // word address inside one bank
  typedef logic [9:0] bank_addr_t;

  // pseudo-peripheral registers
  localparam addr_t PrintAddr      = 32'h1000_0000;
  localparam addr_t TimerMaskAddr  = 32'h1500_0000;
  localparam addr_t TimerCountAddr = 32'h1500_0004;

  // interrupt id, as seen on the ack interface
  typedef logic [4:0] irq_id_t;

  // timer id, also the enable bit in the mask register
  localparam irq_id_t TimerIrqId = 5'd7;

  // request as seen by one RAM bank
  typedef struct packed {
    logic       req;
    logic       we;
    be_t        be;
    bank_addr_t addr;
    data_t      wdata;
  } bank_req_t;

  typedef enum logic [1:0] {
    REG_PRINT,
    REG_TIMER_MASK,
    REG_TIMER_COUNT
  } periph_reg_t;

  // request as seen by the peripheral block
  typedef struct packed {
    logic        req;
    logic        we;
    periph_reg_t sel;
    data_t       wdata;
  } periph_req_t;

  // decoded destination of a data request
  typedef enum logic [1:0] {
    TGT_BANK0,
    TGT_BANK1,
    TGT_PERIPH,
    TGT_ERR
  } target_t;

endpackage

`default_nettype wire

/* obi_pkg.sv */
// bus-level types for the data request port and its response
`default_nettype none

package obi_pkg;

  // byte address
  typedef logic [31:0] addr_t;

  // one data word
  typedef logic [31:0] data_t;

  // one enable per byte lane
  typedef logic [3:0] be_t;

  // request side, driven by the master
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  // response side
  // gnt in the request cycle, rvalid one cycle later
  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    logic  err;
    data_t rdata;
  } obi_resp_t;

endpackage

`default_nettype wire
